// ==== storage_config.svh ====
`ifndef STORAGE_CONFIG_SVH
`define STORAGE_CONFIG_SVH

// Block counts per partition
`define MGMT_BLOCKS 2
`define USER_BLOCKS 4

// 256 words per block
`define RAM_ADDR_W 8

// Only the top address byte selects a window
`define ADR_MASK 32'hFF00_0000

// Management partition, read/write
`define MGMT_BASE0 32'h0100_0000
`define MGMT_BASE1 32'h0200_0000

// User partition, read only from the management side
`define USER_BASE0 32'h0300_0000
`define USER_BASE1 32'h0400_0000
`define USER_BASE2 32'h0500_0000
`define USER_BASE3 32'h0600_0000

// Window with no block behind it
`define UNMAPPED_BASE 32'h0700_0000

`endif

// ==== storage_pkg.sv ====
package storage_pkg;

    // Per-lane acknowledge sequencer
    // IDLE waits for a strobe, READ_WAIT covers the SRAM read latency,
    // DONE is the single ack cycle
    typedef enum logic [1:0] {
        ACK_IDLE      = 2'd0,
        ACK_READ_WAIT = 2'd1,
        ACK_DONE      = 2'd2
    } ack_state_e;

    // Strobe lane owner, also used as an index into wb_stb_i and wb_ack_o
    typedef enum logic {
        PART_MGMT = 1'b0,
        PART_USER = 1'b1
    } partition_e;

endpackage

// ==== storage_mem_if.sv ====
`timescale 1ns/1ps
`include "storage_config.svh"

interface storage_mem_if ();

    // Active-low enable and write enable, one bit per management block
    logic [`MGMT_BLOCKS-1:0]    mem_ena;
    logic [`MGMT_BLOCKS-1:0]    mem_wen;

    // Byte mask, set bits get written
    logic [3:0]                 mem_wen_mask;

    // Shared by all blocks
    logic [`RAM_ADDR_W-1:0]     mem_addr;
    logic [31:0]                mem_wdata;

    // Each block drives its own 32-bit slice
    wire  [`MGMT_BLOCKS*32-1:0] mem_rdata;

    modport bridge (
        output mem_ena,
        output mem_wen,
        output mem_wen_mask,
        output mem_addr,
        output mem_wdata,
        input  mem_rdata
    );

    // Enables and read data go through each block's own ports
    modport mem (
        input  mem_wen_mask,
        input  mem_addr,
        input  mem_wdata
    );

endinterface

// ==== storage_bridge_wb.sv ====
`timescale 1ns/1ps
`include "storage_config.svh"

module storage_bridge_wb
    import storage_pkg::*;
(
    input  logic                      wb_clk_i,
    input  logic                      rst_n_i,

    // Wishbone slave, lane 0 management, lane 1 user
    input  logic [31:0]               wb_adr_i,
    input  logic [31:0]               wb_dat_i,
    input  logic [3:0]                wb_sel_i,
    input  logic                      wb_we_i,
    input  logic                      wb_cyc_i,
    input  logic [1:0]                wb_stb_i,
    output logic [1:0]                wb_ack_o,
    output logic [31:0]               wb_mgmt_dat_o,
    output logic [31:0]               wb_user_dat_o,

    // Management SRAM native pins
    storage_mem_if.bridge             mem,

    // User partition read port
    output logic [`USER_BLOCKS-1:0]   user_rd_ena_o,
    output logic [`RAM_ADDR_W-1:0]    user_rd_addr_o,
    input  logic [`USER_BLOCKS*32-1:0] user_rd_data_i
);

    localparam int WINDOWS = `MGMT_BLOCKS + `USER_BLOCKS;

    // Base table, window 0 in the low word
    localparam logic [WINDOWS*32-1:0] BASE_TABLE = {
        `USER_BASE3,
        `USER_BASE2,
        `USER_BASE1,
        `USER_BASE0,
        `MGMT_BASE1,
        `MGMT_BASE0
    };

    logic [1:0]              valid;
    logic [1:0]              start;
    logic                    mgmt_wr;
    logic [WINDOWS-1:0]      win_sel;
    logic [`MGMT_BLOCKS-1:0] mgmt_sel;
    logic [`USER_BLOCKS-1:0] user_sel;
    logic [`RAM_ADDR_W-1:0]  word_addr;
    ack_state_e              state_q [2];

    // Next state of one lane's ack sequencer
    function automatic ack_state_e next_state(
        input ack_state_e cur,
        input logic       req,
        input logic       we
    );
        ack_state_e nxt;
        nxt = cur;
        case (cur)
            ACK_IDLE: begin
                // Writes commit right away, reads need one more cycle
                if (req) begin
                    nxt = we ? ACK_DONE : ACK_READ_WAIT;
                end
            end
            ACK_READ_WAIT: nxt = ACK_DONE;
            default:       nxt = ACK_IDLE;
        endcase
        return nxt;
    endfunction

    assign valid = {2{wb_cyc_i}} & wb_stb_i;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q[PART_MGMT] <= ACK_IDLE;
            state_q[PART_USER] <= ACK_IDLE;
        end else begin
            for (int l = 0; l < 2; l++) begin
                state_q[l] <= next_state(state_q[l], valid[l], wb_we_i);
            end
        end
    end

    // A lane only touches the SRAMs in its first cycle
    assign start[PART_MGMT] = valid[PART_MGMT] && (state_q[PART_MGMT] == ACK_IDLE);
    assign start[PART_USER] = valid[PART_USER] && (state_q[PART_USER] == ACK_IDLE);

    assign wb_ack_o[PART_MGMT] = (state_q[PART_MGMT] == ACK_DONE);
    assign wb_ack_o[PART_USER] = (state_q[PART_USER] == ACK_DONE);

    // Window decode on the top address byte
    for (genvar w = 0; w < WINDOWS; w++) begin : g_dec
        assign win_sel[w] = ((wb_adr_i & `ADR_MASK) == BASE_TABLE[w*32 +: 32]);
    end

    assign mgmt_sel = win_sel[`MGMT_BLOCKS-1:0];
    assign user_sel = win_sel[WINDOWS-1:`MGMT_BLOCKS];

    // Byte address in, word index out
    assign word_addr = wb_adr_i[`RAM_ADDR_W+1:2];

    // Management blocks
    assign mgmt_wr          = start[PART_MGMT] && wb_we_i;
    assign mem.mem_ena      = start[PART_MGMT] ? ~mgmt_sel : '1;
    assign mem.mem_wen      = mgmt_wr ? ~mgmt_sel : '1;
    assign mem.mem_wen_mask = mgmt_wr ? wb_sel_i : 4'h0;
    assign mem.mem_addr     = word_addr;
    assign mem.mem_wdata    = wb_dat_i;

    // User blocks, read only from here
    assign user_rd_ena_o  = start[PART_USER] ? ~user_sel : '1;
    assign user_rd_addr_o = word_addr;

    // AND-OR read mux, unmapped windows fall out as zero
    always_comb begin
        wb_mgmt_dat_o = '0;
        for (int b = 0; b < `MGMT_BLOCKS; b++) begin
            wb_mgmt_dat_o = wb_mgmt_dat_o | (mem.mem_rdata[b*32 +: 32] & {32{mgmt_sel[b]}});
        end
    end

    always_comb begin
        wb_user_dat_o = '0;
        for (int b = 0; b < `USER_BLOCKS; b++) begin
            wb_user_dat_o = wb_user_dat_o | (user_rd_data_i[b*32 +: 32] & {32{user_sel[b]}});
        end
    end

endmodule

// ==== storage_ram_block.sv ====
`timescale 1ns/1ps
`include "storage_config.svh"

module storage_ram_block (
    input  logic        wb_clk_i,

    // Shared address, data and byte mask
    storage_mem_if.mem  mem,

    // This block's own enables, active low
    input  logic        blk_ena_i,
    input  logic        blk_wen_i,
    output logic [31:0] rd_data_o
);

    localparam int DEPTH = 2 ** `RAM_ADDR_W;

    logic [31:0] ram [DEPTH] = '{default: '0};

    // Read returns the old word on a write to the same address
    always_ff @(posedge wb_clk_i) begin
        if (!blk_ena_i) begin
            if (!blk_wen_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem.mem_wen_mask[b]) begin
                        ram[mem.mem_addr][b*8 +: 8] <= mem.mem_wdata[b*8 +: 8];
                    end
                end
            end
            rd_data_o <= ram[mem.mem_addr];
        end
    end

endmodule

// ==== storage_user_ram.sv ====
`timescale 1ns/1ps
`include "storage_config.svh"

module storage_user_ram (
    input  logic                   wb_clk_i,

    // User-side write, one word per pulse
    input  logic                   user_we_i,
    input  logic [`RAM_ADDR_W-1:0] user_addr_i,
    input  logic [31:0]            user_wdata_i,

    // Management-side read, enable active low
    input  logic                   rd_ena_i,
    input  logic [`RAM_ADDR_W-1:0] rd_addr_i,
    output logic [31:0]            rd_data_o
);

    localparam int DEPTH = 2 ** `RAM_ADDR_W;

    logic [31:0] ram [DEPTH] = '{default: '0};

    always_ff @(posedge wb_clk_i) begin
        if (user_we_i) begin
            ram[user_addr_i] <= user_wdata_i;
        end
        // Registered read, old data if both sides hit the same word
        if (!rd_ena_i) begin
            rd_data_o <= ram[rd_addr_i];
        end
    end

endmodule

// ==== storage_subsystem.sv ====
`timescale 1ns/1ps
`include "storage_config.svh"

module storage_subsystem (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,

    // Wishbone slave
    input  logic [31:0]            wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    input  logic [3:0]             wb_sel_i,
    input  logic                   wb_we_i,
    input  logic                   wb_cyc_i,
    input  logic [1:0]             wb_stb_i,
    output logic [1:0]             wb_ack_o,
    output logic [31:0]            wb_mgmt_dat_o,
    output logic [31:0]            wb_user_dat_o,

    // User area write port
    input  logic                   user_we_i,
    input  logic [1:0]             user_blk_i,
    input  logic [`RAM_ADDR_W-1:0] user_addr_i,
    input  logic [31:0]            user_wdata_i
);

    logic [`USER_BLOCKS-1:0]    user_rd_ena;
    logic [`RAM_ADDR_W-1:0]     user_rd_addr;
    wire  [`USER_BLOCKS*32-1:0] user_rd_data;

    storage_mem_if mem_bus ();

    storage_bridge_wb u_bridge (
        .wb_clk_i       (wb_clk_i),
        .rst_n_i        (rst_n_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_sel_i       (wb_sel_i),
        .wb_we_i        (wb_we_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_ack_o       (wb_ack_o),
        .wb_mgmt_dat_o  (wb_mgmt_dat_o),
        .wb_user_dat_o  (wb_user_dat_o),
        .mem            (mem_bus.bridge),
        .user_rd_ena_o  (user_rd_ena),
        .user_rd_addr_o (user_rd_addr),
        .user_rd_data_i (user_rd_data)
    );

    // Management partition
    for (genvar m = 0; m < `MGMT_BLOCKS; m++) begin : g_mgmt
        logic [31:0] rdata;

        storage_ram_block u_ram (
            .wb_clk_i  (wb_clk_i),
            .mem       (mem_bus.mem),
            .blk_ena_i (mem_bus.mem_ena[m]),
            .blk_wen_i (mem_bus.mem_wen[m]),
            .rd_data_o (rdata)
        );

        assign mem_bus.mem_rdata[m*32 +: 32] = rdata;
    end

    // User partition, write strobe steered by user_blk_i
    for (genvar u = 0; u < `USER_BLOCKS; u++) begin : g_user
        logic blk_we;

        assign blk_we = user_we_i && (user_blk_i == 2'(u));

        storage_user_ram u_ram (
            .wb_clk_i     (wb_clk_i),
            .user_we_i    (blk_we),
            .user_addr_i  (user_addr_i),
            .user_wdata_i (user_wdata_i),
            .rd_ena_i     (user_rd_ena[u]),
            .rd_addr_i    (user_rd_addr),
            .rd_data_o    (user_rd_data[u*32 +: 32])
        );
    end

endmodule

// ==== storage_props.sv ====
`timescale 1ns/1ps
`include "storage_config.svh"

module storage_props
    import storage_pkg::*;
(
    input logic                    wb_clk_i,
    input logic                    rst_n_i,
    input logic                    wb_we_i,
    input logic                    wb_cyc_i,
    input logic [1:0]              wb_stb_i,
    input logic [1:0]              wb_ack_o,
    input logic [`MGMT_BLOCKS-1:0] mem_wen,
    input logic [`USER_BLOCKS-1:0] user_rd_ena_o,
    input ack_state_e              mgmt_state_i,
    input ack_state_e              user_state_i
);

    // Single-cycle ack, sequencer back in IDLE right after
    mgmt_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o[0] |=> (!wb_ack_o[0] && mgmt_state_i == ACK_IDLE))
        else $error("Lane 0 ack longer than one cycle");

    user_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o[1] |=> (!wb_ack_o[1] && user_state_i == ACK_IDLE))
        else $error("Lane 1 ack longer than one cycle");

    mgmt_ack_cause: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $rose(wb_ack_o[0]) |-> $past(wb_cyc_i && wb_stb_i[0]))
        else $error("Lane 0 ack without a strobe");

    user_ack_cause: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $rose(wb_ack_o[1]) |-> $past(wb_cyc_i && wb_stb_i[1]))
        else $error("Lane 1 ack without a strobe");

    // Write enables only from a lane 0 write
    wen_source: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (mem_wen != '1) |-> (wb_cyc_i && wb_stb_i[0] && wb_we_i))
        else $error("SRAM write enable without a lane 0 write");

    user_idle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        !(wb_cyc_i && wb_stb_i[1]) |-> (&user_rd_ena_o))
        else $error("User read enable active while lane 1 idle");

endmodule

bind storage_bridge_wb storage_props u_props (
    .wb_clk_i      (wb_clk_i),
    .rst_n_i       (rst_n_i),
    .wb_we_i       (wb_we_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_o      (wb_ack_o),
    .mem_wen       (mem.mem_wen),
    .user_rd_ena_o (user_rd_ena_o),
    .mgmt_state_i  (state_q[0]),
    .user_state_i  (state_q[1])
);

// ==== tb_storage.sv ====
`timescale 1ns/1ps
`include "storage_config.svh"

module tb_storage
    import storage_pkg::*;
();

    localparam int MAX_CYCLES = 4000;
    localparam int ACK_LIMIT  = 16;
    localparam int UNMAPPED   = 6;

    // Window index 0-1 is management, 2-5 user and 6 unmapped
    localparam logic [31:0] BASES [7] = '{
        `MGMT_BASE0, `MGMT_BASE1,
        `USER_BASE0, `USER_BASE1, `USER_BASE2, `USER_BASE3,
        `UNMAPPED_BASE
    };

    logic        wb_clk;
    logic        rst_n;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_cyc;
    logic [1:0]  wb_stb;
    logic [1:0]  wb_ack;
    logic [31:0] wb_mgmt_dat;
    logic [31:0] wb_user_dat;
    logic        user_we;
    logic [1:0]  user_blk;
    logic [7:0]  user_addr;
    logic [31:0] user_wdata;

    logic [31:0] shadow [6][256];
    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;

    storage_subsystem dut_i (
        .wb_clk_i      (wb_clk),
        .rst_n_i       (rst_n),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat),
        .wb_sel_i      (wb_sel),
        .wb_we_i       (wb_we),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_ack_o      (wb_ack),
        .wb_mgmt_dat_o (wb_mgmt_dat),
        .wb_user_dat_o (wb_user_dat),
        .user_we_i     (user_we),
        .user_blk_i    (user_blk),
        .user_addr_i   (user_addr),
        .user_wdata_i  (user_wdata)
    );

    initial begin
        wb_clk = 1'b0;
        forever #10 wb_clk = ~wb_clk;
    end

    // Hard stop for the whole run
    always @(posedge wb_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout, run exceeded %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] window_addr(int win, logic [7:0] word);
        return BASES[win] | {22'b0, word, 2'b00};
    endfunction

    function automatic int window_of(logic [31:0] addr);
        for (int w = 0; w < UNMAPPED; w++) begin
            if ((addr & `ADR_MASK) == BASES[w]) begin
                return w;
            end
        end
        return UNMAPPED;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] new_word,
                                                logic [3:0] sel);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // A lane only sees its own partition and reads zero elsewhere
    function automatic logic [31:0] expected_read(partition_e lane, logic [31:0] addr);
        int win;
        win = window_of(addr);
        if (lane == PART_MGMT && win < `MGMT_BLOCKS) begin
            return shadow[win][addr[9:2]];
        end
        if (lane == PART_USER && win >= `MGMT_BLOCKS && win < UNMAPPED) begin
            return shadow[win][addr[9:2]];
        end
        return 32'h0;
    endfunction

    // Only lane 0 writes into the management blocks land
    task automatic record_write(partition_e lane, logic [31:0] addr, logic [31:0] data,
                                logic [3:0] sel);
        int win;
        win = window_of(addr);
        if (lane == PART_MGMT && win < `MGMT_BLOCKS) begin
            shadow[win][addr[9:2]] = merge_bytes(shadow[win][addr[9:2]], data, sel);
        end
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s got=%h exp=%h", name, got, exp);
        end
    endtask

    task automatic check_latency(partition_e lane, int got, int exp);
        checks++;
        assert (got >= 0) else begin
            errors++;
            $display("No acknowledge on lane %0d within %0d cycles", lane, ACK_LIMIT);
        end
        if (got >= 0) begin
            assert (got == exp) else begin
                errors++;
                $display("FAIL wb_ack_o latency lane %0d got=%h exp=%h", lane, got, exp);
            end
        end
    endtask

    // One classic Wishbone cycle
    // Latency counts rising edges from the drive edge up to the first cycle with ack
    task automatic wb_access(partition_e lane, logic we, logic [31:0] addr, logic [31:0] data,
                             logic [3:0] sel, output logic [31:0] rdata, output int latency);
        int   cycles;
        logic acked;
        cycles = 0;
        acked  = 1'b0;
        rdata  = 32'h0;
        @(posedge wb_clk);
        wb_cyc <= 1'b1;
        wb_stb <= (lane == PART_USER) ? 2'b10 : 2'b01;
        wb_we  <= we;
        wb_adr <= addr;
        wb_dat <= data;
        wb_sel <= sel;
        // An ack already high before the first sampling edge gives zero latency
        @(negedge wb_clk);
        while (!wb_ack[lane] && cycles < ACK_LIMIT) begin
            @(posedge wb_clk);
            cycles++;
            @(negedge wb_clk);
        end
        if (wb_ack[lane]) begin
            acked = 1'b1;
            rdata = (lane == PART_USER) ? wb_user_dat : wb_mgmt_dat;
        end
        @(posedge wb_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 2'b00;
        wb_we  <= 1'b0;
        latency = acked ? cycles : -1;
    endtask

    task automatic wb_write(partition_e lane, logic [31:0] addr, logic [31:0] data,
                            logic [3:0] sel);
        logic [31:0] rdata;
        int          lat;
        wb_access(lane, 1'b1, addr, data, sel, rdata, lat);
        check_latency(lane, lat, 1);
        record_write(lane, addr, data, sel);
    endtask

    task automatic wb_read(partition_e lane, logic [31:0] addr, logic [31:0] expected);
        logic [31:0] rdata;
        int          lat;
        wb_access(lane, 1'b0, addr, 32'h0, 4'hf, rdata, lat);
        check_latency(lane, lat, 2);
        if (lane == PART_USER) begin
            check_value("wb_user_dat_o", rdata, expected);
        end else begin
            check_value("wb_mgmt_dat_o", rdata, expected);
        end
    endtask

    task automatic user_write(logic [1:0] blk, logic [7:0] addr, logic [31:0] data);
        @(posedge wb_clk);
        user_we    <= 1'b1;
        user_blk   <= blk;
        user_addr  <= addr;
        user_wdata <= data;
        @(posedge wb_clk);
        user_we    <= 1'b0;
        shadow[`MGMT_BLOCKS + int'(blk)][addr] = data;
    endtask

    task automatic reset_state();
        logic [7:0] words [4] = '{8'h00, 8'h01, 8'h7f, 8'hff};
        @(negedge wb_clk);
        check_value("wb_ack_o", {30'b0, wb_ack}, 32'h0);
        for (int w = 0; w <= UNMAPPED; w++) begin
            for (int i = 0; i < 4; i++) begin
                if (w < `MGMT_BLOCKS) begin
                    wb_read(PART_MGMT, window_addr(w, words[i]), 32'h0);
                end else begin
                    wb_read(PART_USER, window_addr(w, words[i]), 32'h0);
                end
            end
        end
    endtask

    // Both blocks read after each write, so aliasing shows up
    task automatic mgmt_read_write();
        logic [31:0] rnd;
        logic [31:0] data;
        int          blk;
        for (int i = 0; i < 40; i++) begin
            rnd  = $random(seed);
            data = $random(seed);
            blk  = int'(rnd[8]);
            wb_write(PART_MGMT, window_addr(blk, rnd[7:0]), data, 4'hf);
            for (int b = 0; b < `MGMT_BLOCKS; b++) begin
                wb_read(PART_MGMT, window_addr(b, rnd[7:0]),
                        expected_read(PART_MGMT, window_addr(b, rnd[7:0])));
            end
        end
    endtask

    task automatic byte_masks();
        logic [31:0] rnd;
        logic [31:0] addr;
        for (int i = 0; i < 32; i++) begin
            rnd  = $random(seed);
            addr = window_addr(int'(rnd[8]), {4'h0, rnd[3:0]});
            wb_write(PART_MGMT, addr, $random(seed), rnd[15:12]);
            wb_read(PART_MGMT, addr, expected_read(PART_MGMT, addr));
        end
    endtask

    task automatic user_partition();
        logic [31:0] rnd;
        logic [31:0] addr;
        for (int i = 0; i < 24; i++) begin
            rnd  = $random(seed);
            addr = window_addr(`MGMT_BLOCKS + int'(rnd[9:8]), rnd[7:0]);
            user_write(rnd[9:8], rnd[7:0], $random(seed));
            wb_read(PART_USER, addr, expected_read(PART_USER, addr));
        end
        // Management writes into the user area are dropped
        for (int i = 0; i < 8; i++) begin
            rnd  = $random(seed);
            addr = window_addr(`MGMT_BLOCKS + int'(rnd[9:8]), rnd[7:0]);
            wb_write(PART_USER, addr, $random(seed), 4'hf);
            wb_read(PART_USER, addr, expected_read(PART_USER, addr));
        end
    endtask

    task automatic unmapped_and_timing();
        logic [31:0] addr;
        addr = window_addr(UNMAPPED, 8'h04);
        wb_write(PART_MGMT, addr, $random(seed), 4'hf);
        wb_read(PART_MGMT, addr, 32'h0);
        wb_write(PART_USER, addr, $random(seed), 4'hf);
        wb_read(PART_USER, addr, 32'h0);
        // Same word in a mapped window stays as it was
        wb_read(PART_MGMT, window_addr(0, 8'h04), expected_read(PART_MGMT, window_addr(0, 8'h04)));
        wb_write(PART_MGMT, window_addr(1, 8'h20), 32'hcafe_f00d, 4'hf);
        wb_read(PART_MGMT, window_addr(1, 8'h20), 32'hcafe_f00d);
    endtask

    initial begin
        seed       = 32'hf96a_3018;
        rst_n      = 1'b0;
        wb_adr     = 32'h0;
        wb_dat     = 32'h0;
        wb_sel     = 4'h0;
        wb_we      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 2'b00;
        user_we    = 1'b0;
        user_blk   = 2'b00;
        user_addr  = 8'h00;
        user_wdata = 32'h0;
        for (int b = 0; b < 6; b++) begin
            for (int w = 0; w < 256; w++) begin
                shadow[b][w] = 32'h0;
            end
        end
        repeat (4) @(posedge wb_clk);
        rst_n <= 1'b1;

        reset_state();
        mgmt_read_write();
        byte_masks();
        user_partition();
        unmapped_and_timing();

        @(posedge wb_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== storage.f ====
+incdir+.
storage_pkg.sv
storage_mem_if.sv
storage_bridge_wb.sv
storage_ram_block.sv
storage_user_ram.sv
storage_subsystem.sv
storage_props.sv
tb_storage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the storage bridge simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_storage -f storage.f \
    --Mdir obj_dir -o tb_storage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_storage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" sim.log; then
    echo "Simulation result: pass"
    exit 0
fi
echo "Simulation result: fail"
exit 1
